// File: include/tcp_consts.svh
`ifndef TCP_CONSTS_SVH
`define TCP_CONSTS_SVH

// bit positions inside the 6-bit flags field
`define TCP_FLAG_FIN 0
`define TCP_FLAG_SYN 1
`define TCP_FLAG_RST 2
`define TCP_FLAG_ACK 4

// connect and disconnect timeout in clock cycles
`define TCP_CONN_TIMEOUT 400

// galois lfsr mask for x^32 + x^22 + x^2 + x + 1
`define TCP_ISN_POLY 32'h8020_0003
`define TCP_ISN_SEED 32'h1f3c_5a97 // must not be zero

// advertised receive window
`define TCP_DEFAULT_WND 16'd4000

// field widths
`define TCP_NUM_W  32
`define TCP_PORT_W 16

`endif

// File: hdl/tcp_pkg.sv
`default_nettype none

`include "tcp_consts.svh"

package tcp_pkg;

  typedef logic [`TCP_NUM_W-1:0]  tcp_num_t;  // seq and ack numbers
  typedef logic [`TCP_PORT_W-1:0] tcp_port_t;

  // status as seen by the user
  typedef enum logic [2:0] {
    tcp_closed,
    tcp_listening,
    tcp_connecting,
    tcp_connected,
    tcp_disconnecting
  } tcp_status_t;

  // header flags with fin in bit 0
  typedef struct packed {
    logic urg;
    logic ack;
    logic psh;
    logic rst;
    logic syn;
    logic fin;
  } tcp_flags_t;

  // how the current connection is being torn down
  typedef enum logic [1:0] {
    close_none,
    close_active,  // user dropped connect or listen
    close_passive, // remote sent fin
    close_reset    // remote sent rst
  } tcp_close_t;

endpackage

`default_nettype wire

// File: hdl/tcp_isn_gen.sv
`default_nettype none

`include "tcp_consts.svh"

module tcp_isn_gen (
  input  wire               clk,
  input  wire               rst_rec,
  output tcp_pkg::tcp_num_t isn
);

  logic fb; // bit shifted out this cycle

  assign fb = isn[0];

  // galois form folds the mask in whenever a one leaves the register
  always_ff @(posedge clk) begin
    if (rst_rec) begin
      isn <= `TCP_ISN_SEED;
    end else if (fb) begin
      isn <= {1'b0, isn[`TCP_NUM_W-1:1]} ^ `TCP_ISN_POLY;
    end else begin
      isn <= {1'b0, isn[`TCP_NUM_W-1:1]};
    end
  end

endmodule

`default_nettype wire

// File: hdl/tcp_rx_filter.sv
`default_nettype none

`include "tcp_consts.svh"

module tcp_rx_filter (
  input  wire                  clk,
  input  wire                  rst_rec,
  input  wire                  rx_valid,
  input  wire tcp_pkg::tcp_port_t  rx_src_port,
  input  wire tcp_pkg::tcp_port_t  rx_dst_port,
  input  wire tcp_pkg::tcp_num_t   rx_seq,
  input  wire tcp_pkg::tcp_num_t   rx_ack,
  input  wire tcp_pkg::tcp_flags_t rx_flags,
  input  wire tcp_pkg::tcp_port_t  listen_port,
  input  wire tcp_pkg::tcp_port_t  conn_loc_port,
  input  wire tcp_pkg::tcp_port_t  conn_rem_port,
  output logic                 evt_syn,
  output logic                 evt_syn_ack,
  output logic                 evt_ack,
  output logic                 evt_fin,
  output logic                 evt_rst,
  output tcp_pkg::tcp_num_t    evt_seq,
  output tcp_pkg::tcp_num_t    evt_ack_num
);

  logic lsn_hit;  // addressed to the open local port for the handshake
  logic conn_hit; // both ports belong to the current connection

  assign lsn_hit  = rx_valid && (rx_dst_port == listen_port);
  assign conn_hit = rx_valid && (rx_src_port == conn_rem_port) &&
                    (rx_dst_port == conn_loc_port);

  always_ff @(posedge clk) begin
    if (rst_rec) begin
      evt_syn     <= 1'b0;
      evt_syn_ack <= 1'b0;
      evt_ack     <= 1'b0;
      evt_fin     <= 1'b0;
      evt_rst     <= 1'b0;
    end else begin
      evt_syn     <= lsn_hit && (rx_flags == 6'(1 << `TCP_FLAG_SYN)); // bare syn only
      evt_syn_ack <= lsn_hit && rx_flags.syn && rx_flags.ack;
      evt_ack     <= conn_hit && rx_flags.ack;
      evt_fin     <= conn_hit && rx_flags.fin;
      evt_rst     <= conn_hit && rx_flags.rst;
    end
  end

  // numbers ride along with the event pulses
  always_ff @(posedge clk) begin
    evt_seq     <= rx_seq;
    evt_ack_num <= rx_ack;
  end

endmodule

`default_nettype wire

// File: hdl/tcp_conn_timer.sv
`default_nettype none

`include "tcp_consts.svh"

module tcp_conn_timer #(
  parameter int TICKS = `TCP_CONN_TIMEOUT
) (
  input  wire  clk,
  input  wire  rst_rec,
  input  wire  tmr_en,
  output logic tmr_expire
);

  localparam int CNT_W = $clog2(TICKS + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (rst_rec || !tmr_en) begin // count only while enabled
      cnt        <= '0;
      tmr_expire <= 1'b0;
    end else if (cnt == CNT_W'(TICKS - 1)) begin
      cnt        <= '0; // restart after the pulse
      tmr_expire <= 1'b1;
    end else begin
      cnt        <= cnt + 1'b1;
      tmr_expire <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/tcp_conn_fsm.sv
`default_nettype none

`include "tcp_consts.svh"

module tcp_conn_fsm (
  input  wire                   clk,
  input  wire                   rst_rec,
  input  wire                   connect,
  input  wire                   listen,
  input  wire tcp_pkg::tcp_port_t loc_port,
  input  wire tcp_pkg::tcp_port_t rem_port,
  input  wire                   evt_syn,
  input  wire                   evt_syn_ack,
  input  wire                   evt_ack,
  input  wire                   evt_fin,
  input  wire                   evt_rst,
  input  wire tcp_pkg::tcp_num_t  evt_seq,
  input  wire tcp_pkg::tcp_num_t  evt_ack_num,
  input  wire tcp_pkg::tcp_num_t  isn,
  input  wire                   tmr_expire,
  output logic                  tmr_en,
  output tcp_pkg::tcp_port_t    conn_loc_port,
  output tcp_pkg::tcp_port_t    conn_rem_port,
  output tcp_pkg::tcp_status_t  status,
  output logic                  seg_valid,
  input  wire                   seg_ready,
  output tcp_pkg::tcp_flags_t   seg_flags,
  output tcp_pkg::tcp_port_t    seg_src_port,
  output tcp_pkg::tcp_port_t    seg_dst_port,
  output tcp_pkg::tcp_num_t     seg_seq,
  output tcp_pkg::tcp_num_t     seg_ack,
  output logic [15:0]           seg_wnd
);

  import tcp_pkg::*;

  localparam logic [5:0] FL_FIN = 6'(1 << `TCP_FLAG_FIN);
  localparam logic [5:0] FL_SYN = 6'(1 << `TCP_FLAG_SYN);
  localparam logic [5:0] FL_RST = 6'(1 << `TCP_FLAG_RST);
  localparam logic [5:0] FL_ACK = 6'(1 << `TCP_FLAG_ACK);

  typedef enum logic [3:0] {
    closed_s, listen_s, syn_send_s, syn_wait_s, ack_send_s, synack_send_s,
    synack_wait_s, established_s, dcn_fin_s, dcn_fin_wait_s, dcn_ack_s,
    dcn_last_s, dcn_rst_s, done_s
  } state_t;

  state_t      state;
  tcp_num_t    loc_seq;
  tcp_num_t    loc_ack;
  tcp_close_t  close_kind;
  logic        passive_open; // connection came from listen
  logic        got_ack;      // ack seen while waiting for the remote fin
  logic        clr_pend;
  logic        clr_go;
  logic        fin_clr;
  logic        usr_dcn;
  logic        xfer;
  logic        is_send;
  logic [5:0]  snd_flags;
  tcp_num_t    snd_seq;
  tcp_num_t    snd_ack;
  tcp_status_t st_cur;

  assign xfer    = seg_valid && seg_ready;
  assign usr_dcn = passive_open ? !listen : !connect;
  assign fin_clr = (state == done_s);
  assign clr_go  = clr_pend && (!seg_valid || seg_ready); // never drop a segment mid-handshake
  assign seg_wnd = `TCP_DEFAULT_WND;
  assign is_send = state inside {syn_send_s, ack_send_s, synack_send_s,
                                 dcn_fin_s, dcn_ack_s, dcn_rst_s};

  // fields of the segment owed by the current send state
  always_comb begin
    snd_flags = FL_ACK;
    snd_seq   = loc_seq;
    snd_ack   = loc_ack;
    case (state)
      syn_send_s: begin
        snd_flags = FL_SYN;
        snd_ack   = '0;
      end
      synack_send_s: snd_flags = FL_SYN | FL_ACK;
      dcn_fin_s:     snd_flags = FL_FIN | FL_ACK;
      dcn_ack_s:     snd_ack   = loc_ack + 1'b1; // acknowledge the remote fin
      dcn_rst_s:     snd_flags = FL_RST | FL_ACK;
      default: ;
    endcase
  end

  // a timeout or finished close is applied once the output is idle
  always_ff @(posedge clk) begin
    if (rst_rec || clr_go) begin
      clr_pend <= 1'b0;
    end else if (tmr_expire || fin_clr) begin
      clr_pend <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_rec || clr_go) begin
      state         <= closed_s;
      seg_valid     <= 1'b0;
      close_kind    <= close_none;
      passive_open  <= 1'b0;
      got_ack       <= 1'b0;
      conn_loc_port <= '0;
      conn_rem_port <= '0;
    end else begin
      if (is_send && !seg_valid) begin
        seg_valid <= 1'b1;
        seg_flags <= snd_flags;
        seg_seq   <= snd_seq;
        seg_ack   <= snd_ack;
      end
      if (xfer) seg_valid <= 1'b0;
      case (state)
        closed_s: begin
          close_kind    <= close_none;
          got_ack       <= 1'b0;
          conn_loc_port <= loc_port;
          conn_rem_port <= rem_port;
          seg_src_port  <= loc_port;
          seg_dst_port  <= rem_port;
          if (listen) begin
            passive_open <= 1'b1;
            state        <= listen_s;
          end else if (connect) begin
            passive_open <= 1'b0;
            loc_seq      <= isn;
            state        <= syn_send_s;
          end
        end
        ////////////////////////////////////////
        // open sequences
        ////////////////////////////////////////
        listen_s: begin
          if (!listen) begin
            state <= closed_s;
          end else if (evt_syn) begin
            loc_seq <= isn;
            loc_ack <= evt_seq + 1'b1;
            state   <= synack_send_s;
          end
        end
        syn_send_s: if (xfer) state <= syn_wait_s;
        syn_wait_s: begin
          if (evt_syn_ack && (evt_ack_num == loc_seq + 1'b1)) begin // must ack our isn
            loc_seq <= loc_seq + 1'b1;
            loc_ack <= evt_seq + 1'b1;
            state   <= ack_send_s;
          end
        end
        ack_send_s:    if (xfer) state <= established_s;
        synack_send_s: if (xfer) state <= synack_wait_s;
        synack_wait_s: begin
          if (evt_ack && (evt_seq == loc_ack)) begin
            loc_seq <= loc_seq + 1'b1;
            state   <= established_s;
          end
        end
        established_s: begin
          if (usr_dcn) begin
            close_kind <= close_active;
            state      <= dcn_fin_s;
          end else if (evt_fin) begin
            close_kind <= close_passive;
            state      <= dcn_ack_s;
          end else if (evt_rst) begin
            close_kind <= close_reset;
            state      <= dcn_rst_s;
          end
        end
        ////////////////////////////////////////
        // close sequences
        ////////////////////////////////////////
        dcn_fin_s: begin
          if (xfer) state <= (close_kind == close_passive) ? dcn_last_s : dcn_fin_wait_s;
        end
        dcn_fin_wait_s: begin // ack first, then the remote fin
          if (evt_ack) got_ack <= 1'b1;
          if (evt_fin && got_ack) state <= dcn_ack_s;
        end
        dcn_ack_s: begin
          if (xfer) begin
            loc_ack <= loc_ack + 1'b1;
            state   <= (close_kind == close_passive) ? dcn_fin_s : done_s;
          end
        end
        dcn_last_s: if (evt_ack) state <= done_s;
        dcn_rst_s:  if (xfer) state <= done_s;
        default: ; // done_s waits for the clear
      endcase
    end
  end

  always_comb begin
    case (state)
      listen_s: st_cur = tcp_listening;
      syn_send_s, syn_wait_s, ack_send_s, synack_send_s, synack_wait_s:
        st_cur = tcp_connecting;
      established_s: st_cur = tcp_connected;
      dcn_fin_s, dcn_fin_wait_s, dcn_ack_s, dcn_last_s, dcn_rst_s:
        st_cur = tcp_disconnecting;
      default: st_cur = tcp_closed;
    endcase
  end

  // status and timer enable trail the state by one cycle
  always_ff @(posedge clk) begin
    if (rst_rec || clr_go) begin
      status <= tcp_closed;
      tmr_en <= 1'b0;
    end else begin
      status <= st_cur;
      tmr_en <= st_cur inside {tcp_connecting, tcp_disconnecting};
    end
  end

endmodule

`default_nettype wire

// File: hdl/tcp_conn_engine.sv
`default_nettype none

module tcp_conn_engine (
  input  wire                    clk,
  input  wire                    rst_rec,
  // user control
  input  wire                    connect,
  input  wire                    listen,
  input  wire tcp_pkg::tcp_port_t  loc_port,
  input  wire tcp_pkg::tcp_port_t  rem_port,
  output tcp_pkg::tcp_status_t   status,
  // received segments
  input  wire                    rx_valid,
  input  wire tcp_pkg::tcp_port_t  rx_src_port,
  input  wire tcp_pkg::tcp_port_t  rx_dst_port,
  input  wire tcp_pkg::tcp_num_t   rx_seq,
  input  wire tcp_pkg::tcp_num_t   rx_ack,
  input  wire tcp_pkg::tcp_flags_t rx_flags,
  // outgoing segments
  output logic                   seg_valid,
  input  wire                    seg_ready,
  output tcp_pkg::tcp_flags_t    seg_flags,
  output tcp_pkg::tcp_port_t     seg_src_port,
  output tcp_pkg::tcp_port_t     seg_dst_port,
  output tcp_pkg::tcp_num_t      seg_seq,
  output tcp_pkg::tcp_num_t      seg_ack,
  output logic [15:0]            seg_wnd
);

  import tcp_pkg::*;

  logic      evt_syn, evt_syn_ack, evt_ack, evt_fin, evt_rst;
  tcp_num_t  evt_seq, evt_ack_num;
  tcp_num_t  isn;
  tcp_port_t conn_loc_port, conn_rem_port;
  logic      tmr_en, tmr_expire;

  tcp_isn_gen isn_gen0 (.clk(clk), .rst_rec(rst_rec), .isn(isn));

  tcp_rx_filter rx_filter0 (
    .clk(clk), .rst_rec(rst_rec), .rx_valid(rx_valid),
    .rx_src_port(rx_src_port), .rx_dst_port(rx_dst_port),
    .rx_seq(rx_seq), .rx_ack(rx_ack), .rx_flags(rx_flags),
    .listen_port(loc_port), // handshake is matched against the user port
    .conn_loc_port(conn_loc_port), .conn_rem_port(conn_rem_port),
    .evt_syn(evt_syn), .evt_syn_ack(evt_syn_ack), .evt_ack(evt_ack),
    .evt_fin(evt_fin), .evt_rst(evt_rst),
    .evt_seq(evt_seq), .evt_ack_num(evt_ack_num)
  );

  tcp_conn_timer conn_timer0 (
    .clk(clk), .rst_rec(rst_rec), .tmr_en(tmr_en), .tmr_expire(tmr_expire)
  );

  tcp_conn_fsm conn_fsm0 (
    .clk(clk), .rst_rec(rst_rec), .connect(connect), .listen(listen),
    .loc_port(loc_port), .rem_port(rem_port),
    .evt_syn(evt_syn), .evt_syn_ack(evt_syn_ack), .evt_ack(evt_ack),
    .evt_fin(evt_fin), .evt_rst(evt_rst),
    .evt_seq(evt_seq), .evt_ack_num(evt_ack_num),
    .isn(isn), .tmr_expire(tmr_expire), .tmr_en(tmr_en),
    .conn_loc_port(conn_loc_port), .conn_rem_port(conn_rem_port), .status(status),
    .seg_valid(seg_valid), .seg_ready(seg_ready), .seg_flags(seg_flags),
    .seg_src_port(seg_src_port), .seg_dst_port(seg_dst_port),
    .seg_seq(seg_seq), .seg_ack(seg_ack), .seg_wnd(seg_wnd)
  );

endmodule

`default_nettype wire

// File: tb/tcp_conn_engine_chk.sv
`default_nettype none

module tcp_conn_engine_chk (
  input wire                       clk,
  input wire                       rst_rec,
  input wire                       seg_valid,
  input wire                       seg_ready,
  input wire tcp_pkg::tcp_flags_t  seg_flags,
  input wire tcp_pkg::tcp_port_t   seg_src_port,
  input wire tcp_pkg::tcp_port_t   seg_dst_port,
  input wire tcp_pkg::tcp_num_t    seg_seq,
  input wire tcp_pkg::tcp_num_t    seg_ack,
  input wire tcp_pkg::tcp_status_t status,
  input wire                       tmr_en
);

  import tcp_pkg::*;

  int fail_cnt = 0;

  // a stalled segment keeps its place and its fields
  seg_hold_a: assert property (@(posedge clk) disable iff (rst_rec)
    seg_valid && !seg_ready |=> seg_valid && $stable(seg_flags) && $stable(seg_seq) &&
      $stable(seg_ack) && $stable(seg_src_port) && $stable(seg_dst_port))
    else begin
      fail_cnt++;
      $error("segment dropped or changed while stalled");
    end

  rst_state_a: assert property (@(posedge clk)
    rst_rec |=> !seg_valid && status == tcp_closed && !tmr_en) // idle right after reset
    else begin
      fail_cnt++;
      $error("engine not idle after reset");
    end

endmodule

`default_nettype wire

// File: tb/tcp_conn_engine_tb.sv
`default_nettype none

`include "tcp_consts.svh"

module tcp_conn_engine_tb;

  import tcp_pkg::*;

  localparam int N_SCEN     = 20;
  localparam int MAX_CYCLES = N_SCEN * (`TCP_CONN_TIMEOUT + 200);
  localparam int SEG_WAIT   = 60; // cycles allowed for one segment to leave

  localparam logic [5:0] F_FIN = 6'b1 << `TCP_FLAG_FIN;
  localparam logic [5:0] F_SYN = 6'b1 << `TCP_FLAG_SYN;
  localparam logic [5:0] F_RST = 6'b1 << `TCP_FLAG_RST;
  localparam logic [5:0] F_ACK = 6'b1 << `TCP_FLAG_ACK;

  logic        clk;
  logic        rst_rec;
  logic        connect;
  logic        listen;
  tcp_port_t   loc_port;
  tcp_port_t   rem_port;
  tcp_status_t status;
  logic        rx_valid;
  tcp_port_t   rx_src_port;
  tcp_port_t   rx_dst_port;
  tcp_num_t    rx_seq;
  tcp_num_t    rx_ack;
  tcp_flags_t  rx_flags;
  logic        seg_valid;
  logic        seg_ready;
  tcp_flags_t  seg_flags;
  tcp_port_t   seg_src_port;
  tcp_port_t   seg_dst_port;
  tcp_num_t    seg_seq;
  tcp_num_t    seg_ack;
  logic [15:0] seg_wnd;

  // accepted segments packed as {flags, src, dst, seq, ack, wnd}
  logic [117:0] seg_q[$];
  tcp_port_t    lp;
  tcp_port_t    rp;
  tcp_num_t     m_lseq; // expected local seq once connected
  tcp_num_t     m_lack; // expected local ack once connected
  int           errors;
  int           cycles;

  tcp_conn_engine dut0 (.*);

  bind tcp_conn_engine tcp_conn_engine_chk chk0 (
    .clk(clk), .rst_rec(rst_rec), .seg_valid(seg_valid), .seg_ready(seg_ready),
    .seg_flags(seg_flags), .seg_src_port(seg_src_port), .seg_dst_port(seg_dst_port),
    .seg_seq(seg_seq), .seg_ack(seg_ack),
    .status(status), .tmr_en(tmr_en)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) seg_ready <= ($urandom % 100) < 60; // ready ~60% of cycles

  // a transfer happens at the next rising edge
  always @(negedge clk) begin
    if (!rst_rec && seg_valid && seg_ready)
      seg_q.push_back({seg_flags, seg_src_port, seg_dst_port, seg_seq, seg_ack, seg_wnd});
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
  endtask

  task automatic next_seg(output logic [117:0] s);
    int n;
    n = 0;
    s = '0;
    while (seg_q.size() == 0 && n < SEG_WAIT) begin
      @(posedge clk);
      n++;
    end
    if (seg_q.size() == 0) begin
      errors++;
      $display("no segment left the engine within %0d cycles", SEG_WAIT);
    end else begin
      s = seg_q.pop_front();
    end
  endtask

  task automatic check_seg(input logic [117:0] s, input logic [5:0] fl, input tcp_num_t seq,
                           input tcp_num_t ack, input logic with_seq);
    if (s[117:112] !== fl) report_mismatch("seg_flags", 32'(s[117:112]), 32'(fl));
    if (s[111:96] !== lp) report_mismatch("seg_src_port", 32'(s[111:96]), 32'(lp));
    if (s[95:80] !== rp) report_mismatch("seg_dst_port", 32'(s[95:80]), 32'(rp));
    if (with_seq && s[79:48] !== seq) report_mismatch("seg_seq", s[79:48], seq);
    if (s[47:16] !== ack) report_mismatch("seg_ack", s[47:16], ack);
    if (s[15:0] !== `TCP_DEFAULT_WND) report_mismatch("seg_wnd", 32'(s[15:0]),
                                                      32'(`TCP_DEFAULT_WND));
  endtask

  task automatic send_rx(input tcp_port_t src, input tcp_port_t dst, input tcp_num_t seq,
                         input tcp_num_t ack, input logic [5:0] fl);
    @(posedge clk);
    rx_valid    <= 1'b1;
    rx_src_port <= src;
    rx_dst_port <= dst;
    rx_seq      <= seq;
    rx_ack      <= ack;
    rx_flags    <= fl;
    @(posedge clk);
    rx_valid <= 1'b0; // one-cycle pulse
  endtask

  task automatic wait_status(input tcp_status_t st, input int lim);
    int n;
    n = 0;
    while (status !== st && n < lim) begin
      @(posedge clk);
      n++;
    end
    if (status !== st) begin
      errors++;
      $display("status did not become %s within %0d cycles", st.name(), lim);
    end
  endtask

  ////////////////////////////////////////
  // scenarios
  ////////////////////////////////////////
  task automatic active_open();
    logic [117:0] s;
    tcp_num_t     r;
    tcp_num_t     isn_seen;
    r = $urandom;
    @(posedge clk);
    loc_port <= lp;
    rem_port <= rp;
    connect  <= 1'b1;
    next_seg(s);
    check_seg(s, F_SYN, '0, '0, 1'b0);
    isn_seen = s[79:48];
    send_rx(rp, lp, r, isn_seen + 1, F_SYN | F_ACK);
    next_seg(s);
    check_seg(s, F_ACK, isn_seen + 1, r + 1, 1'b1);
    m_lseq = isn_seen + 1;
    m_lack = r + 1;
    wait_status(tcp_connected, 20);
  endtask

  task automatic passive_open();
    logic [117:0] s;
    tcp_num_t     r;
    tcp_num_t     isn_seen;
    r = $urandom;
    @(posedge clk);
    loc_port <= lp;
    rem_port <= rp;
    listen   <= 1'b1;
    wait_status(tcp_listening, 10);
    send_rx(rp, lp ^ 16'h0101, r, '0, F_SYN); // wrong local port
    repeat (6) @(posedge clk);
    if (seg_q.size() != 0 || status !== tcp_listening) begin
      errors++;
      $display("a SYN to a foreign port disturbed the listening engine");
    end
    send_rx(rp, lp, r, '0, F_SYN);
    next_seg(s);
    check_seg(s, F_SYN | F_ACK, '0, r + 1, 1'b0);
    isn_seen = s[79:48];
    send_rx(rp, lp, r + 1, isn_seen + 1, F_ACK);
    m_lseq = isn_seen + 1;
    m_lack = r + 1;
    wait_status(tcp_connected, 20);
  endtask

  task automatic active_close();
    logic [117:0] s;
    @(posedge clk);
    connect <= 1'b0;
    listen  <= 1'b0;
    next_seg(s);
    check_seg(s, F_FIN | F_ACK, m_lseq, m_lack, 1'b1);
    send_rx(rp, lp, m_lack, m_lseq + 1, F_ACK);
    send_rx(rp, lp, m_lack, m_lseq + 1, F_FIN | F_ACK);
    next_seg(s);
    check_seg(s, F_ACK, m_lseq, m_lack + 1, 1'b1);
    wait_status(tcp_closed, 20);
  endtask

  task automatic passive_close();
    logic [117:0] s;
    send_rx(rp, lp, m_lack, m_lseq, F_FIN | F_ACK);
    next_seg(s);
    check_seg(s, F_ACK, m_lseq, m_lack + 1, 1'b1);
    next_seg(s);
    check_seg(s, F_FIN | F_ACK, m_lseq, m_lack + 1, 1'b1);
    listen <= 1'b0; // no reopen after the close
    send_rx(rp, lp, m_lack + 1, m_lseq + 1, F_ACK);
    wait_status(tcp_closed, 20);
  endtask

  task automatic reset_close();
    logic [117:0] s;
    send_rx(rp ^ 16'h0040, lp, m_lack, m_lseq, F_RST);
    repeat (6) @(posedge clk);
    if (seg_q.size() != 0 || status !== tcp_connected) begin
      errors++;
      $display("an RST from a foreign port changed the connection");
    end
    send_rx(rp, lp, m_lack, m_lseq, F_RST);
    next_seg(s);
    check_seg(s, F_RST | F_ACK, m_lseq, m_lack, 1'b1);
    connect <= 1'b0;
    wait_status(tcp_closed, 20);
  endtask

  task automatic conn_timeout();
    logic [117:0] s;
    @(posedge clk);
    loc_port <= lp;
    rem_port <= rp;
    connect  <= 1'b1;
    next_seg(s);
    check_seg(s, F_SYN, '0, '0, 1'b0);
    connect <= 1'b0; // remote stays silent
    wait_status(tcp_closed, `TCP_CONN_TIMEOUT + 10);
  endtask

  task automatic idle_check(input int scen);
    repeat (8) @(posedge clk);
    if (seg_q.size() != 0) begin
      errors++;
      $display("%0d extra segment(s) after scenario %0d", seg_q.size(), scen);
      seg_q.delete();
    end
    if (status !== tcp_closed) begin
      errors++;
      $display("engine not closed after scenario %0d", scen);
    end
  endtask

  initial begin
    void'($urandom(32'h3acd6663));
    errors      = 0;
    rst_rec     = 1'b1;
    connect     = 1'b0;
    listen      = 1'b0;
    loc_port    = '0;
    rem_port    = '0;
    rx_valid    = 1'b0;
    rx_src_port = '0;
    rx_dst_port = '0;
    rx_seq      = '0;
    rx_ack      = '0;
    rx_flags    = '0;
    seg_ready   = 1'b0;
    repeat (3) @(posedge clk);
    rst_rec <= 1'b0;
    for (int i = 0; i < N_SCEN; i++) begin
      lp = 16'($urandom);
      rp = 16'($urandom);
      case (i % 5)
        0: begin
          active_open();
          active_close();
        end
        1: begin
          passive_open();
          passive_close();
        end
        2: begin
          active_open();
          reset_close();
        end
        3: begin
          passive_open();
          active_close();
        end
        default: conn_timeout();
      endcase
      idle_check(i);
    end
    $display("checks done: %0d model errors, %0d assertion failures",
             errors, dut0.chk0.fail_cnt);
    if (errors == 0 && dut0.chk0.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles before all scenarios finished", cycles);
    $display("checks done: %0d model errors, %0d assertion failures",
             errors, dut0.chk0.fail_cnt);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
hdl/tcp_pkg.sv
hdl/tcp_isn_gen.sv
hdl/tcp_rx_filter.sv
hdl/tcp_conn_timer.sv
hdl/tcp_conn_fsm.sv
hdl/tcp_conn_engine.sv
tb/tcp_conn_engine_chk.sv
tb/tcp_conn_engine_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tcp_conn_engine_tb
FILELIST   := tb.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_ARGS   := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := TEST PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
